// File: include/board_ctrl_settings.svh
// board control settings
// widths, register map, debounce time
`ifndef BOARD_CTRL_SETTINGS_SVH
`define BOARD_CTRL_SETTINGS_SVH

// ==============================
// board widths
`define BC_KEY_W            2           // push buttons in use
`define BC_LED_W            10          // red leds
`define BC_HEX_DIGITS       6           // seven-segment digits
`define BC_CMD_W            8           // spi command byte
`define BC_DEBOUNCE_CYCLES  50000       // 1 ms at 50 MHz

// ==============================
// wishbone register map, word addresses
`define BC_ADDR_CMD         2'd0
`define BC_ADDR_KEYS        2'd1
`define BC_ADDR_LED         2'd2
`define BC_ADDR_HEX         2'd3
`define BC_WB_AW            2           // word address width
`define BC_WB_DW            32          // bus data width

`endif

// File: rtl/board_ctrl_pkg.sv
// board control shared types
`default_nettype none
`include "board_ctrl_settings.svh"

package board_ctrl_pkg;

        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [`BC_WB_AW-1:0]   adr;            // word address
                logic [`BC_WB_DW-1:0]   dat_w;
        } wb_req_t;                                     // master to slave

        typedef struct packed {
                logic                   ack;
                logic [`BC_WB_DW-1:0]   dat_r;
        } wb_rsp_t;

        typedef struct packed {
                logic   sclk;
                logic   csel_n;
                logic   mosi;
        } spi_pins_t;

        typedef struct packed {
                logic                   valid;          // one-cycle strobe
                logic [`BC_CMD_W-1:0]   data;           // received byte
        } spi_cmd_t;

        typedef struct packed {
                logic [`BC_HEX_DIGITS-1:0][3:0] nib;    // nib[0] is the rightmost digit
        } hex_digits_t;

        // active-low glyphs, segment a in bit 0, g in bit 6
        function automatic logic [6:0] seg_glyph(input logic [3:0] nibble);
                case (nibble)
                        4'h0: return 7'h40;
                        4'h1: return 7'h79;
                        4'h2: return 7'h24;
                        4'h3: return 7'h30;
                        4'h4: return 7'h19;
                        4'h5: return 7'h12;
                        4'h6: return 7'h02;
                        4'h7: return 7'h78;
                        4'h8: return 7'h00;
                        4'h9: return 7'h10;
                        4'ha: return 7'h08;
                        4'hb: return 7'h03;             // lower case b
                        4'hc: return 7'h46;
                        4'hd: return 7'h21;             // lower case d
                        4'he: return 7'h06;
                        default: return 7'h0e;          // F
                endcase
        endfunction

endpackage

`default_nettype wire

// File: rtl/cdc_sync.sv
// two-stage input synchronizer
`timescale 1ns/10ps
`default_nettype none

module cdc_sync #(
        parameter type T = logic                // payload, pins or vectors
) (
        input  logic    clock_50,
        input  logic    rst,
        input  T        d,                      // asynchronous pins
        output T        q                       // safe to use in clock_50 domain
);

        T meta;                                 // first stage, may go metastable

        // resets to all ones, the idle level of the
        // active-low pins that pass through here
        always_ff @(posedge clock_50) begin
                if (rst) begin
                        meta <= T'('1);
                        q    <= T'('1);
                end else begin
                        meta <= d;
                        q    <= meta;           // second stage settles
                end
        end

endmodule

`default_nettype wire

// File: rtl/key_debounce.sv
// key debouncer
// active-low keys to pressed flags
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module key_debounce #(
        parameter int DEBOUNCE_CYCLES = `BC_DEBOUNCE_CYCLES     // stable time in clocks
) (
        input  logic                    clock_50,
        input  logic                    rst,
        input  logic [`BC_KEY_W-1:0]    key_n,          // synchronized, active low
        output logic [`BC_KEY_W-1:0]    pressed         // debounced, active high
);

        localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
        localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

        logic [`BC_KEY_W-1:0][CNT_W-1:0] cnt;           // one stable-time counter per key

        // ==============================
        // per-key filter
        // counter runs only while the pin disagrees with the flag,
        // so a short glitch restarts it from zero
        always_ff @(posedge clock_50) begin
                if (rst) begin
                        cnt     <= '0;
                        pressed <= '0;
                end else begin
                        for (int i = 0; i < `BC_KEY_W; i++) begin
                                if (~key_n[i] == pressed[i]) begin
                                        cnt[i] <= '0;                   // level agrees
                                end else if (cnt[i] == CNT_LAST) begin
                                        pressed[i] <= ~key_n[i];        // held long enough
                                        cnt[i]     <= '0;
                                end else begin
                                        cnt[i] <= cnt[i] + 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: rtl/spi_cmd_receiver.sv
// spi mode-0 command receiver
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module spi_cmd_receiver
        import board_ctrl_pkg::*;
(
        input  logic            clock_50,
        input  logic            rst,
        input  spi_pins_t       pins,           // already synchronized
        output logic            miso,
        output spi_cmd_t        cmd
);

        localparam int CNT_W = $clog2(`BC_CMD_W);
        localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`BC_CMD_W - 1);

        logic                   sclk_d;         // sclk one cycle back
        logic                   sclk_rise;
        logic                   sclk_fall;
        logic [CNT_W-1:0]       bit_cnt;        // bits taken in this byte
        logic [`BC_CMD_W-1:0]   rx_shift;
        logic [`BC_CMD_W-1:0]   rx_next;
        logic [`BC_CMD_W-1:0]   tx_shift;       // previous byte, msb on miso

        assign sclk_rise = pins.sclk & ~sclk_d & ~pins.csel_n;
        assign sclk_fall = ~pins.sclk & sclk_d & ~pins.csel_n;
        assign rx_next   = {rx_shift[`BC_CMD_W-2:0], pins.mosi};    // msb first
        assign miso      = tx_shift[`BC_CMD_W-1];

        // ==============================
        // shift engine
        always_ff @(posedge clock_50) begin
                if (rst) begin
                        sclk_d    <= 1'b1;              // matches synchronizer idle
                        bit_cnt   <= '0;
                        rx_shift  <= '0;
                        tx_shift  <= '0;
                        cmd.valid <= 1'b0;
                        cmd.data  <= '0;
                end else begin
                        sclk_d    <= pins.sclk;
                        cmd.valid <= 1'b0;                      // strobe by default
                        if (pins.csel_n) begin
                                bit_cnt <= '0;                  // deselect restarts the byte
                        end else if (sclk_rise) begin
                                rx_shift <= rx_next;
                                bit_cnt  <= bit_cnt + 1'b1;     // wraps after last bit
                                if (bit_cnt == BIT_LAST) begin
                                        cmd.valid <= 1'b1;
                                        cmd.data  <= rx_next;
                                        tx_shift  <= rx_next;   // echoed on next transfer
                                end
                        end else if (sclk_fall && bit_cnt != '0) begin
                                // the fall right after the last bit is skipped,
                                // keeping the new byte's msb on the pin
                                tx_shift <= {tx_shift[`BC_CMD_W-2:0], 1'b0};
                        end
                end
        end

endmodule

`default_nettype wire

// File: rtl/wb_reg_bank.sv
// wishbone classic register bank
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module wb_reg_bank
        import board_ctrl_pkg::*;
(
        input  logic                    clock_50,
        input  logic                    rst,
        input  wb_req_t                 wb_req,
        output wb_rsp_t                 wb_rsp,
        input  spi_cmd_t                cmd,            // one-cycle pulse per byte
        input  logic [`BC_KEY_W-1:0]    pressed,
        output logic [`BC_LED_W-1:0]    led,
        output hex_digits_t             hex
);

        localparam int DW    = `BC_WB_DW;
        localparam int HEX_W = 4 * `BC_HEX_DIGITS;

        logic                   bus_hit;        // new cycle, not yet acked
        logic                   wr_en;
        logic                   rd_cmd;         // read of CMD being acked
        logic                   ready;
        logic [`BC_CMD_W-1:0]   cmd_byte;       // last received command

        assign bus_hit = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
        assign wr_en   = bus_hit & wb_req.we;
        assign rd_cmd  = bus_hit & ~wb_req.we & (wb_req.adr == `BC_ADDR_CMD);

        // ==============================
        // ack, writes and command state
        always_ff @(posedge clock_50) begin
                if (rst) begin
                        wb_rsp.ack <= 1'b0;
                        ready      <= 1'b0;
                        cmd_byte   <= '0;
                        led        <= '0;
                        hex        <= '0;
                end else begin
                        wb_rsp.ack <= bus_hit;                  // single cycle, then low
                        if (cmd.valid) begin
                                ready    <= 1'b1;               // new byte beats the clear
                                cmd_byte <= cmd.data;
                        end else if (rd_cmd) begin
                                ready <= 1'b0;
                        end
                        if (wr_en) begin
                                case (wb_req.adr)
                                        `BC_ADDR_LED: led <= wb_req.dat_w[`BC_LED_W-1:0];
                                        `BC_ADDR_HEX: hex <= hex_digits_t'(wb_req.dat_w[HEX_W-1:0]);
                                        default: ;              // cmd and keys read only
                                endcase
                        end
                end
        end

        // ==============================
        // read data, valid with ack
        always_ff @(posedge clock_50) begin
                if (bus_hit) begin
                        case (wb_req.adr)
                                `BC_ADDR_CMD:  wb_rsp.dat_r <= DW'({ready, cmd_byte});
                                `BC_ADDR_KEYS: wb_rsp.dat_r <= DW'(pressed);
                                `BC_ADDR_LED:  wb_rsp.dat_r <= DW'(led);
                                default:       wb_rsp.dat_r <= DW'(hex);
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: rtl/hex_display.sv
// six-digit seven-segment encoder
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module hex_display
        import board_ctrl_pkg::*;
(
        input  logic            clock_50,
        input  logic            rst,
        input  hex_digits_t     digits,
        output logic [6:0]      hex0,           // rightmost digit
        output logic [6:0]      hex1,
        output logic [6:0]      hex2,
        output logic [6:0]      hex3,
        output logic [6:0]      hex4,
        output logic [6:0]      hex5            // leftmost digit
);

        logic [`BC_HEX_DIGITS-1:0][6:0] seg_q;  // registered patterns

        // registered so the segment pins never glitch while a nibble changes
        always_ff @(posedge clock_50) begin
                if (rst) begin
                        seg_q <= {`BC_HEX_DIGITS{seg_glyph(4'h0)}};    // all show 0
                end else begin
                        for (int i = 0; i < `BC_HEX_DIGITS; i++) begin
                                seg_q[i] <= seg_glyph(digits.nib[i]);
                        end
                end
        end

        assign hex0 = seg_q[0];
        assign hex1 = seg_q[1];
        assign hex2 = seg_q[2];
        assign hex3 = seg_q[3];
        assign hex4 = seg_q[4];
        assign hex5 = seg_q[5];

endmodule

`default_nettype wire

// File: rtl/board_ctrl_top.sv
// board control top level
// spi command, keys, leds and hex display
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module board_ctrl_top
        import board_ctrl_pkg::*;
#(
        parameter int DEBOUNCE_CYCLES = `BC_DEBOUNCE_CYCLES
) (
        input  logic                    clock_50,
        input  logic                    rst,
        input  logic [`BC_KEY_W-1:0]    key_n,
        input  logic                    spi_sclk,
        input  logic                    spi_csel_n,
        input  logic                    spi_mosi,
        output logic                    spi_miso,
        input  wb_req_t                 wb_req,         // host bus
        output wb_rsp_t                 wb_rsp,
        output logic [`BC_LED_W-1:0]    led,
        output logic [6:0]              hex0,
        output logic [6:0]              hex1,
        output logic [6:0]              hex2,
        output logic [6:0]              hex3,
        output logic [6:0]              hex4,
        output logic [6:0]              hex5
);

        spi_pins_t              spi_raw;        // straight from the header pins
        spi_pins_t              spi_sync;
        logic [`BC_KEY_W-1:0]   key_sync_n;
        logic [`BC_KEY_W-1:0]   pressed;
        spi_cmd_t               cmd;
        hex_digits_t            hex_val;

        assign spi_raw = '{sclk: spi_sclk, csel_n: spi_csel_n, mosi: spi_mosi};

        // ==============================
        // decode
        cdc_sync #(.T(spi_pins_t)) u_spi_sync (
                .clock_50 (clock_50),
                .rst      (rst),
                .d        (spi_raw),
                .q        (spi_sync)
        );

        cdc_sync #(.T(logic [`BC_KEY_W-1:0])) u_key_sync (
                .clock_50 (clock_50),
                .rst      (rst),
                .d        (key_n),
                .q        (key_sync_n)
        );

        spi_cmd_receiver u_spi_rx (
                .clock_50 (clock_50),
                .rst      (rst),
                .pins     (spi_sync),
                .miso     (spi_miso),
                .cmd      (cmd)
        );

        key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce (
                .clock_50 (clock_50),
                .rst      (rst),
                .key_n    (key_sync_n),
                .pressed  (pressed)
        );

        // ==============================
        // execute and result
        wb_reg_bank u_regs (
                .clock_50 (clock_50),
                .rst      (rst),
                .wb_req   (wb_req),
                .wb_rsp   (wb_rsp),
                .cmd      (cmd),
                .pressed  (pressed),
                .led      (led),
                .hex      (hex_val)
        );

        hex_display u_hex (
                .clock_50 (clock_50),
                .rst      (rst),
                .digits   (hex_val),
                .hex0     (hex0),
                .hex1     (hex1),
                .hex2     (hex2),
                .hex3     (hex3),
                .hex4     (hex4),
                .hex5     (hex5)
        );

endmodule

`default_nettype wire

// File: testbench/board_ctrl_checker.sv
// wishbone ack checks
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_checker
        import board_ctrl_pkg::*;
(
        input  logic            clock_50,
        input  logic            rst,
        input  wb_req_t         wb_req,
        input  wb_rsp_t         wb_rsp
);

        int unsigned fail_count = 0;            // failed assertions so far

        // ==============================
        // ack rules
        ack_follows_request: assert property (@(posedge clock_50) disable iff (rst)
                wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
                else begin
                        $error("ack without cyc and stb in the cycle before");
                        fail_count++;
                end

        ack_single_cycle: assert property (@(posedge clock_50) disable iff (rst)
                wb_rsp.ack |=> !wb_rsp.ack)
                else begin
                        $error("ack held for more than one cycle");
                        fail_count++;
                end

        ack_low_in_reset: assert property (@(posedge clock_50)
                rst |=> !wb_rsp.ack)
                else begin
                        $error("ack high while in reset");
                        fail_count++;
                end

endmodule

bind wb_reg_bank board_ctrl_checker u_checker (
        .clock_50 (clock_50),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
);

`default_nettype wire

// File: testbench/board_ctrl_tb.sv
// board control testbench
// bus, spi and key stimulus against a reference model
`timescale 1ns/10ps
`default_nettype none
`include "board_ctrl_settings.svh"

module board_ctrl_tb
        import board_ctrl_pkg::*;
();

        localparam int DEBOUNCE   = 16;         // short filter for simulation
        localparam int SPI_HALF   = 4;          // clocks per sclk half period
        localparam int ACK_LIMIT  = 20;         // cycles to wait for ack
        localparam int POLL_LIMIT = 40;         // register polls before giving up
        localparam int WATCHDOG   = 50000;

        logic                           clock_50;
        logic                           rst;
        logic [`BC_KEY_W-1:0]           key_n;
        logic                           spi_sclk;
        logic                           spi_csel_n;
        logic                           spi_mosi;
        logic                           spi_miso;
        wb_req_t                        wb_req;
        wb_rsp_t                        wb_rsp;
        logic [`BC_LED_W-1:0]           led;
        logic [6:0]                     hex0;
        logic [6:0]                     hex1;
        logic [6:0]                     hex2;
        logic [6:0]                     hex3;
        logic [6:0]                     hex4;
        logic [6:0]                     hex5;
        logic [`BC_HEX_DIGITS-1:0][6:0] seg_bus;        // seg_bus[0] is hex0

        // reference model
        logic [`BC_LED_W-1:0]           model_led;
        logic [4*`BC_HEX_DIGITS-1:0]    model_hex;
        logic [`BC_CMD_W-1:0]           model_cmd;
        logic [`BC_KEY_W-1:0]           model_pressed;
        logic [31:0]                    lfsr;
        int                             error_count;
        int                             check_count;
        int                             test_count;

        assign seg_bus = {hex5, hex4, hex3, hex2, hex1, hex0};

        board_ctrl_top #(.DEBOUNCE_CYCLES(DEBOUNCE)) DUT (
                .clock_50 (clock_50),
                .rst      (rst),
                .key_n    (key_n),
                .spi_sclk (spi_sclk),
                .spi_csel_n (spi_csel_n),
                .spi_mosi (spi_mosi),
                .spi_miso (spi_miso),
                .wb_req   (wb_req),
                .wb_rsp   (wb_rsp),
                .led      (led),
                .hex0     (hex0),
                .hex1     (hex1),
                .hex2     (hex2),
                .hex3     (hex3),
                .hex4     (hex4),
                .hex5     (hex5)
        );

        initial begin
                clock_50 = 1'b0;
                forever #5 clock_50 = ~clock_50;        // 10 ns period
        end

        // ==============================
        // helpers
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
        endfunction

        task automatic random_bits(input int nbits, output logic [31:0] value);
                value = '0;
                for (int i = 0; i < nbits; i++) begin
                        lfsr  = lfsr_next(lfsr);                // one step per bit
                        value = {value[30:0], lfsr[0]};
                end
        endtask

        // active-low segments, a in bit 0
        function automatic logic [6:0] glyph_model(input logic [3:0] n);
                case (n)
                        4'h0: return 7'b1000000;
                        4'h1: return 7'b1111001;
                        4'h2: return 7'b0100100;
                        4'h3: return 7'b0110000;
                        4'h4: return 7'b0011001;
                        4'h5: return 7'b0010010;
                        4'h6: return 7'b0000010;
                        4'h7: return 7'b1111000;
                        4'h8: return 7'b0000000;
                        4'h9: return 7'b0010000;
                        4'ha: return 7'b0001000;
                        4'hb: return 7'b0000011;
                        4'hc: return 7'b1000110;
                        4'hd: return 7'b0100001;
                        4'he: return 7'b0000110;
                        default: return 7'b0001110;
                endcase
        endfunction

        task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                                   input string msg);
                check_count++;
                if (got !== exp) begin
                        error_count++;
                        $display("CHECK FAILED at %0t: %s, got %h expected %h",
                                 $time, msg, got, exp);
                end
        endtask

        task automatic report_test(input string name, input int start_errors);
                test_count++;
                $display("test %0d %s: %s", test_count, name,
                         (error_count == start_errors) ? "ok" : "failed");
        endtask

        task automatic bus_access(input logic we, input logic [`BC_WB_AW-1:0] adr,
                                  input logic [31:0] data, output logic [31:0] rdata);
                int waited;
                waited = 0;
                rdata  = '0;
                @(posedge clock_50);
                wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data};
                @(negedge clock_50);
                while (!wb_rsp.ack && waited < ACK_LIMIT) begin
                        waited++;
                        @(negedge clock_50);
                end
                if (wb_rsp.ack) begin
                        rdata = wb_rsp.dat_r;                   // valid with ack
                end else begin
                        error_count++;
                        $display("bus cycle to address %0d got no ack", adr);
                end
                @(posedge clock_50);
                wb_req <= '0;                                   // drop stb after ack
        endtask

        task automatic bus_write(input logic [`BC_WB_AW-1:0] adr, input logic [31:0] data);
                logic [31:0] unused;
                bus_access(1'b1, adr, data, unused);
        endtask

        task automatic bus_read(input logic [`BC_WB_AW-1:0] adr, output logic [31:0] data);
                bus_access(1'b0, adr, '0, data);
        endtask

        // mode 0, msb first; miso sampled just before each rising sclk
        task automatic spi_send_byte(input logic [7:0] data, output logic [7:0] echoed);
                echoed = '0;
                @(posedge clock_50);
                spi_csel_n <= 1'b0;
                for (int b = 7; b >= 0; b--) begin
                        spi_mosi <= data[b];                    // sclk is low here
                        repeat (SPI_HALF - 1) @(posedge clock_50);
                        @(negedge clock_50);
                        echoed = {echoed[6:0], spi_miso};
                        @(posedge clock_50);
                        spi_sclk <= 1'b1;
                        repeat (SPI_HALF) @(posedge clock_50);
                        spi_sclk <= 1'b0;
                end
                repeat (SPI_HALF) @(posedge clock_50);
                spi_csel_n <= 1'b1;                             // end of transfer
                repeat (SPI_HALF) @(posedge clock_50);
        endtask

        task automatic wait_command(output logic [31:0] value);
                int polls;
                polls = 0;
                bus_read(`BC_ADDR_CMD, value);
                while (!value[`BC_CMD_W] && polls < POLL_LIMIT) begin
                        polls++;
                        bus_read(`BC_ADDR_CMD, value);
                end
                if (!value[`BC_CMD_W]) begin
                        error_count++;
                        $display("no spi command became ready in time");
                end
        endtask

        task automatic wait_keys(input logic [`BC_KEY_W-1:0] expected);
                logic [31:0] value;
                int          polls;
                polls = 0;
                bus_read(`BC_ADDR_KEYS, value);
                while (value !== 32'(expected) && polls < POLL_LIMIT) begin
                        polls++;
                        bus_read(`BC_ADDR_KEYS, value);
                end
                if (value !== 32'(expected)) begin
                        error_count++;
                        $display("pressed flags never reached %b", expected);
                end
        endtask

        task automatic check_segments(input string what);
                repeat (2) @(posedge clock_50);                 // register plus encoder
                @(negedge clock_50);
                for (int i = 0; i < `BC_HEX_DIGITS; i++) begin
                        check_value(32'(seg_bus[i]), 32'(glyph_model(model_hex[4*i +: 4])),
                                    $sformatf("hex%0d %s", i, what));
                end
        endtask

        // ==============================
        // watchdog
        initial begin
                repeat (WATCHDOG) @(posedge clock_50);
                $display("simulation ran past its cycle limit");
                $display("TEST FAIL");
                $finish;
        end

        // ==============================
        // test sequence
        initial begin
                logic [31:0] rd;
                logic [31:0] rnd;
                logic [7:0]  echoed;
                int          start;
                rst           = 1'b1;
                key_n         = '1;                             // keys released
                spi_sclk      = 1'b0;
                spi_csel_n    = 1'b1;
                spi_mosi      = 1'b0;
                wb_req        = '0;
                lfsr          = 32'h931;
                model_led     = '0;
                model_hex     = '0;
                model_cmd     = '0;
                model_pressed = '0;
                error_count   = 0;
                check_count   = 0;
                test_count    = 0;
                repeat (2) @(posedge clock_50);
                rst <= 1'b0;

                start = error_count;                            // reset state
                @(negedge clock_50);
                check_value(32'(led), 32'(model_led), "led pins after reset");
                check_value(32'(spi_miso), 32'h0, "miso after reset");
                check_segments("after reset");
                bus_read(`BC_ADDR_LED, rd);
                check_value(rd, 32'(model_led), "LED register after reset");
                bus_read(`BC_ADDR_CMD, rd);
                check_value(rd, 32'h0, "CMD register after reset");
                bus_read(`BC_ADDR_KEYS, rd);
                check_value(rd, 32'(model_pressed), "KEYS register after reset");
                report_test("reset state", start);

                start = error_count;                            // led register
                for (int n = 0; n < 8; n++) begin
                        random_bits(32, rnd);
                        bus_write(`BC_ADDR_LED, rnd);
                        model_led = rnd[`BC_LED_W-1:0];         // upper bits dropped
                        bus_read(`BC_ADDR_LED, rd);
                        check_value(rd, 32'(model_led), "LED readback");
                        @(negedge clock_50);
                        check_value(32'(led), 32'(model_led), "led pins");
                end
                report_test("led register", start);

                start = error_count;                            // hex register
                for (int n = 0; n < 8; n++) begin
                        random_bits(4 * `BC_HEX_DIGITS, rnd);
                        bus_write(`BC_ADDR_HEX, rnd);
                        model_hex = rnd[4*`BC_HEX_DIGITS-1:0];
                        check_segments("after HEX write");
                        bus_read(`BC_ADDR_HEX, rd);
                        check_value(rd, 32'(model_hex), "HEX readback");
                end
                report_test("hex display", start);

                start = error_count;                            // spi command
                random_bits(8, rnd);
                spi_send_byte(rnd[7:0], echoed);
                model_cmd = rnd[7:0];
                wait_command(rd);
                check_value(rd, {23'b0, 1'b1, model_cmd}, "CMD after spi byte");
                bus_read(`BC_ADDR_CMD, rd);
                check_value(rd, {23'b0, 1'b0, model_cmd}, "CMD ready cleared by read");
                report_test("spi command", start);

                start = error_count;                            // miso echo
                for (int n = 0; n < 4; n++) begin
                        random_bits(8, rnd);
                        spi_send_byte(rnd[7:0], echoed);
                        check_value(32'(echoed), 32'(model_cmd), "miso echo of previous byte");
                        model_cmd = rnd[7:0];
                        wait_command(rd);
                        check_value(rd, {23'b0, 1'b1, model_cmd}, "CMD after echo transfer");
                end
                report_test("miso echo", start);

                start = error_count;                            // key debounce
                for (int k = 0; k < `BC_KEY_W; k++) begin
                        @(posedge clock_50);
                        key_n[k] <= 1'b0;                       // long press
                        repeat (40) @(posedge clock_50);
                        model_pressed[k] = 1'b1;
                        bus_read(`BC_ADDR_KEYS, rd);
                        check_value(rd, 32'(model_pressed), "KEYS with key held");
                        @(posedge clock_50);
                        key_n[k] <= 1'b1;
                        model_pressed[k] = 1'b0;
                        wait_keys(model_pressed);
                        @(posedge clock_50);
                        key_n[k] <= 1'b0;                       // short glitch
                        repeat (8) @(posedge clock_50);
                        key_n[k] <= 1'b1;
                        for (int n = 0; n < 14; n++) begin      // a false flag outlasts a poll
                                bus_read(`BC_ADDR_KEYS, rd);
                                check_value(rd, 32'(model_pressed), "KEYS after short pulse");
                        end
                end
                report_test("key debounce", start);

                error_count += int'(DUT.u_regs.u_checker.fail_count);
                $display("tests %0d, checks %0d, failures %0d",
                         test_count, check_count, error_count);
                if (error_count == 0) begin
                        $display("TEST PASS");
                end else begin
                        $display("TEST FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
rtl/board_ctrl_pkg.sv
rtl/cdc_sync.sv
rtl/key_debounce.sv
rtl/spi_cmd_receiver.sv
rtl/wb_reg_bank.sv
rtl/hex_display.sv
rtl/board_ctrl_top.sv
testbench/board_ctrl_checker.sv
testbench/board_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the board control testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module board_ctrl_tb -f compile.f &&
{
        sim_out=$(./obj_dir/Vboard_ctrl_tb +verilator+error+limit+100 2>&1)
        printf '%s\n' "$sim_out"
} &&
printf '%s\n' "$sim_out" | grep -qx "TEST PASS" &&
echo "simulation passed" ||
{
        echo "simulation failed"
        exit 1
}
